// ==== dec_macros.svh ====
// Decimator shared constants
`ifndef DEC_MACROS_SVH
`define DEC_MACROS_SVH

// Width of the raw ADC sample held in the low bits of each input word
`define DEC_SAMPLE_WIDTH 12

// Register word indices, byte address is the index times four
`define DEC_REG_VERSION 5'd0
`define DEC_REG_RATIO   5'd1
`define DEC_REG_CONTROL 5'd2
`define DEC_REG_SCRATCH 5'd3

// Core identification word returned by the VERSION register
`define DEC_VERSION_VALUE 32'h0001_0200

// Decimation ratio loaded at reset, one means no rate reduction
`define DEC_RATIO_RESET 16'd1

`endif

// ==== dec_bus_pkg.sv ====
// Decimator bus types
`default_nettype none

package dec_bus_pkg;

  // AXI response codes, the core only ever answers OKAY
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10
  } resp_e;

  // All master driven AXI4-Lite signals
  typedef struct packed {
    logic       awvalid;
    logic [6:0] awaddr;
    logic       wvalid;
    logic [31:0] wdata;
    logic [3:0] wstrb;
    logic       bready;
    logic       arvalid;
    logic [6:0] araddr;
    logic       rready;
  } axi_req_t;

  // All slave driven AXI4-Lite signals
  typedef struct packed {
    logic        awready;
    logic        wready;
    logic        bvalid;
    resp_e       bresp;
    logic        arready;
    logic        rvalid;
    logic [31:0] rdata;
    resp_e       rresp;
  } axi_rsp_t;

  // Single cycle access towards the register bank
  typedef struct packed {
    logic        wreq;
    logic        rreq;
    logic [4:0]  addr;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
  } reg_req_t;

endpackage

`default_nettype wire

// ==== dec_dsp_pkg.sv ====
// Decimator datapath types
`default_nettype none

package dec_dsp_pkg;

  // Channel operating modes
  // Encoding 3 is unused and the register bank folds it into bypass
  typedef enum logic [1:0] {
    MODE_BYPASS  = 2'd0,
    MODE_PICK    = 2'd1,
    MODE_AVERAGE = 2'd2
  } mode_e;

  // Configuration shared by both channels
  typedef struct packed {
    logic [15:0] ratio;
    mode_e       mode;
    logic [3:0]  shift;
  } dec_cfg_t;

  // One sample word with its qualifier
  // Inputs carry the raw ADC code in the low bits, outputs use all 16 bits
  typedef struct packed {
    logic        valid;
    logic [15:0] data;
  } sample_t;

endpackage

`default_nettype wire

// ==== dec_axi_lite_slave.sv ====
// AXI4-Lite register slave
`default_nettype none

module dec_axi_lite_slave (
  input  wire                          adc_clk,
  input  wire                          rst_n,
  input  wire dec_bus_pkg::axi_req_t   axi_req,
  input  wire [31:0]                   rdata,
  output dec_bus_pkg::axi_rsp_t        axi_rsp,
  output dec_bus_pkg::reg_req_t        reg_req
);

  // **********************************************************
  // Accept logic
  // **********************************************************

  logic        wr_take;
  logic        rd_take;
  logic        bvalid_q;
  logic        rvalid_q;
  logic [31:0] rdata_q;

  // A write needs address and data together and a free B channel
  assign wr_take = axi_req.awvalid & axi_req.wvalid & ~bvalid_q;

  // A read waits for a free R channel and yields to a write in the same cycle
  assign rd_take = axi_req.arvalid & ~rvalid_q & ~wr_take;

  // **********************************************************
  // Register access
  // **********************************************************

  // The access lasts exactly the handshake cycle
  // Byte addresses become word indices by dropping the two low bits
  always_comb begin
    reg_req.wreq  = wr_take;
    reg_req.rreq  = rd_take;
    reg_req.addr  = wr_take ? axi_req.awaddr[6:2] : axi_req.araddr[6:2];
    reg_req.wdata = axi_req.wdata;
    reg_req.wstrb = axi_req.wstrb;
  end

  // **********************************************************
  // Response channels
  // **********************************************************

  // Both valids rise on the edge after the handshake and hold until accepted
  always_ff @(posedge adc_clk or negedge rst_n) begin
    if (!rst_n) begin
      bvalid_q <= 1'b0;
      rvalid_q <= 1'b0;
    end else begin
      if (wr_take) begin
        bvalid_q <= 1'b1;
      end else if (axi_req.bready) begin
        bvalid_q <= 1'b0;
      end
      if (rd_take) begin
        rvalid_q <= 1'b1;
      end else if (axi_req.rready) begin
        rvalid_q <= 1'b0;
      end
    end
  end

  // Read data is sampled once and stays stable while rvalid waits for rready
  always_ff @(posedge adc_clk) begin
    if (rd_take) begin
      rdata_q <= rdata;
    end
  end

  // Readies are pulses in the accept cycle only
  always_comb begin
    axi_rsp.awready = wr_take;
    axi_rsp.wready  = wr_take;
    axi_rsp.bvalid  = bvalid_q;
    axi_rsp.bresp   = dec_bus_pkg::OKAY;
    axi_rsp.arready = rd_take;
    axi_rsp.rvalid  = rvalid_q;
    axi_rsp.rdata   = rdata_q;
    axi_rsp.rresp   = dec_bus_pkg::OKAY;
  end

endmodule

`default_nettype wire

// ==== dec_regs.sv ====
// Decimator register bank
`default_nettype none

`include "dec_macros.svh"

module dec_regs (
  input  wire                          adc_clk,
  input  wire                          rst_n,
  input  wire dec_bus_pkg::reg_req_t   reg_req,
  output logic [31:0]                  rdata,
  output dec_dsp_pkg::dec_cfg_t        cfg
);

  logic [15:0] ratio_q;
  logic [1:0]  mode_q;
  logic [3:0]  shift_q;
  logic [31:0] scratch_q;
  logic [31:0] ratio_rd;
  logic [31:0] control_rd;
  logic [31:0] ratio_wr;
  logic [31:0] control_wr;
  logic [31:0] scratch_wr;

  // Replace only the bytes whose strobe is set
  function automatic logic [31:0] merge_bytes(input logic [31:0] old_val,
                                              input logic [31:0] new_val,
                                              input logic [3:0]  strb);
    logic [31:0] res;
    int          i;
    res = old_val;
    for (i = 0; i < 4; i++) begin
      if (strb[i]) begin
        res[8*i +: 8] = new_val[8*i +: 8];
      end
    end
    return res;
  endfunction

  // Readback images of the stored fields, unused bits read as zero
  assign ratio_rd   = {16'd0, ratio_q};
  assign control_rd = {24'd0, shift_q, 2'b00, mode_q};

  assign ratio_wr   = merge_bytes(ratio_rd, reg_req.wdata, reg_req.wstrb);
  assign control_wr = merge_bytes(control_rd, reg_req.wdata, reg_req.wstrb);
  assign scratch_wr = merge_bytes(scratch_q, reg_req.wdata, reg_req.wstrb);

  // **********************************************************
  // Write side
  // **********************************************************

  always_ff @(posedge adc_clk or negedge rst_n) begin
    if (!rst_n) begin
      ratio_q   <= `DEC_RATIO_RESET;
      mode_q    <= 2'd0;
      shift_q   <= 4'd0;
      scratch_q <= 32'd0;
    end else if (reg_req.wreq) begin
      case (reg_req.addr)
        // A zero ratio has no meaning and is kept as one
        `DEC_REG_RATIO: ratio_q <= (ratio_wr[15:0] == 16'd0) ? 16'd1 : ratio_wr[15:0];
        `DEC_REG_CONTROL: begin
          mode_q  <= control_wr[1:0];
          shift_q <= control_wr[7:4];
        end
        `DEC_REG_SCRATCH: scratch_q <= scratch_wr;
        default: ;
      endcase
    end
  end

  // **********************************************************
  // Read side and configuration
  // **********************************************************

  always_comb begin
    case (reg_req.addr)
      `DEC_REG_VERSION: rdata = `DEC_VERSION_VALUE;
      `DEC_REG_RATIO:   rdata = ratio_rd;
      `DEC_REG_CONTROL: rdata = control_rd;
      `DEC_REG_SCRATCH: rdata = scratch_q;
      default:          rdata = 32'd0;
    endcase
  end

  // The reserved mode code runs the channels in bypass
  always_comb begin
    cfg.ratio = ratio_q;
    cfg.mode  = (mode_q == 2'd3) ? dec_dsp_pkg::MODE_BYPASS : dec_dsp_pkg::mode_e'(mode_q);
    cfg.shift = shift_q;
  end

endmodule

`default_nettype wire

// ==== dec_channel.sv ====
// Single decimation channel
`default_nettype none

`include "dec_macros.svh"

module dec_channel (
  input  wire                          adc_clk,
  input  wire                          rst_n,
  input  wire dec_dsp_pkg::dec_cfg_t   cfg,
  input  wire dec_dsp_pkg::sample_t    in_sample,
  output dec_dsp_pkg::sample_t         out_sample
);

  dec_dsp_pkg::dec_cfg_t cfg_q;
  logic                  cfg_chg;
  logic [15:0]           cnt_q;
  logic [15:0]           cnt_eff;
  logic signed [31:0]    acc_q;
  logic signed [31:0]    acc_sum;
  logic signed [31:0]    avg;
  logic signed [31:0]    in_ext;
  logic                  first;
  logic                  last;
  logic                  emit;
  logic [15:0]           emit_data;
  logic                  out_valid_q;
  logic [15:0]           out_data_q;

  // Sign extend the raw ADC code from the low bits of the input word
  assign in_ext = {{(32-`DEC_SAMPLE_WIDTH){in_sample.data[`DEC_SAMPLE_WIDTH-1]}},
                   in_sample.data[`DEC_SAMPLE_WIDTH-1:0]};

  // A new configuration restarts the group
  // The sample arriving in that same cycle opens the new group
  assign cfg_chg = (cfg != cfg_q);
  assign cnt_eff = cfg_chg ? 16'd0 : cnt_q;
  assign first   = (cnt_eff == 16'd0);
  assign last    = ({1'b0, cnt_eff} + 17'd1 >= {1'b0, cfg.ratio});

  // Running group sum including the current sample
  assign acc_sum = (first ? 32'sd0 : acc_q) + in_ext;
  assign avg     = acc_sum >>> cfg.shift;

  // Mode select, any code other than pick or average passes every sample
  always_comb begin
    case (cfg.mode)
      dec_dsp_pkg::MODE_PICK: begin
        emit      = first;
        emit_data = in_ext[15:0];
      end
      dec_dsp_pkg::MODE_AVERAGE: begin
        emit      = last;
        emit_data = avg[15:0];
      end
      default: begin
        emit      = 1'b1;
        emit_data = in_ext[15:0];
      end
    endcase
  end

  // **********************************************************
  // Group state and output register
  // **********************************************************

  always_ff @(posedge adc_clk or negedge rst_n) begin
    if (!rst_n) begin
      cfg_q       <= '{ratio: `DEC_RATIO_RESET, mode: dec_dsp_pkg::MODE_BYPASS, shift: 4'd0};
      cnt_q       <= 16'd0;
      acc_q       <= 32'sd0;
      out_valid_q <= 1'b0;
    end else begin
      cfg_q       <= cfg;
      out_valid_q <= in_sample.valid & emit;
      if (in_sample.valid) begin
        if (last) begin
          cnt_q <= 16'd0;
          acc_q <= 32'sd0;
        end else begin
          cnt_q <= cnt_eff + 16'd1;
          acc_q <= acc_sum;
        end
      end else if (cfg_chg) begin
        cnt_q <= 16'd0;
        acc_q <= 32'sd0;
      end
    end
  end

  // Output data only matters while the valid bit is set
  always_ff @(posedge adc_clk) begin
    if (in_sample.valid & emit) begin
      out_data_q <= emit_data;
    end
  end

  assign out_sample = '{valid: out_valid_q, data: out_data_q};

endmodule

`default_nettype wire

// ==== dec_top.sv ====
// Two channel ADC decimator
`default_nettype none

module dec_top (
  input  wire                          adc_clk,
  input  wire                          rst_n,

  // Host register port
  input  wire dec_bus_pkg::axi_req_t   axi_req,
  output wire dec_bus_pkg::axi_rsp_t   axi_rsp,

  // Sample streams, the ADC code sits in the low bits of each input word
  input  wire dec_dsp_pkg::sample_t    in_a,
  input  wire dec_dsp_pkg::sample_t    in_b,
  output wire dec_dsp_pkg::sample_t    out_a,
  output wire dec_dsp_pkg::sample_t    out_b
);

  // **********************************************************
  // Control path
  // **********************************************************

  wire [31:0]                 reg_rdata;
  wire dec_bus_pkg::reg_req_t reg_req;
  wire dec_dsp_pkg::dec_cfg_t cfg;

  // Bus handshakes become one cycle register accesses
  dec_axi_lite_slave u_slave (
    .adc_clk (adc_clk),
    .rst_n   (rst_n),
    .axi_req (axi_req),
    .rdata   (reg_rdata),
    .axi_rsp (axi_rsp),
    .reg_req (reg_req)
  );

  // Ratio, mode and shift live here and feed both channels
  dec_regs u_regs (
    .adc_clk (adc_clk),
    .rst_n   (rst_n),
    .reg_req (reg_req),
    .rdata   (reg_rdata),
    .cfg     (cfg)
  );

  // **********************************************************
  // Datapath
  // **********************************************************

  // Both channels share one configuration but keep their own group state
  dec_channel u_chan_a (
    .adc_clk    (adc_clk),
    .rst_n      (rst_n),
    .cfg        (cfg),
    .in_sample  (in_a),
    .out_sample (out_a)
  );

  dec_channel u_chan_b (
    .adc_clk    (adc_clk),
    .rst_n      (rst_n),
    .cfg        (cfg),
    .in_sample  (in_b),
    .out_sample (out_b)
  );

endmodule

`default_nettype wire

// ==== tb_dec_top.sv ====
// Decimator testbench
`default_nettype none

`include "dec_macros.svh"

module tb_dec_top;

  // Stimulus takes about 1500 cycles and the limit allows four times that
  localparam int STIM_CYCLES = 1500;
  localparam int MAX_CYCLES  = 4 * STIM_CYCLES;

  logic                  adc_clk;
  logic                  rst_n;
  dec_bus_pkg::axi_req_t axi_req;
  wire dec_bus_pkg::axi_rsp_t axi_rsp;
  dec_dsp_pkg::sample_t  in_a;
  dec_dsp_pkg::sample_t  in_b;
  wire dec_dsp_pkg::sample_t out_a;
  wire dec_dsp_pkg::sample_t out_b;

  // Reference model state holds one register image and one group state per channel
  logic [15:0]           m_ratio;
  logic [1:0]            m_mode;
  logic [3:0]            m_shift;
  logic [31:0]           m_scratch;
  logic [16:0]           m_cnt [2];
  logic signed [31:0]    m_acc [2];
  dec_dsp_pkg::dec_cfg_t cfg_prev;
  dec_dsp_pkg::sample_t  exp_a;
  dec_dsp_pkg::sample_t  exp_b;
  logic [31:0]           rng = 32'h74b6;
  int                    cycles = 0;
  int                    n_out_a = 0;
  int                    n_out_b = 0;

  dec_top u_dec_top (
    .adc_clk (adc_clk),
    .rst_n   (rst_n),
    .axi_req (axi_req),
    .axi_rsp (axi_rsp),
    .in_a    (in_a),
    .in_b    (in_b),
    .out_a   (out_a),
    .out_b   (out_b)
  );

  initial adc_clk = 1'b0;
  always #20 adc_clk = ~adc_clk;

  // ************************************************************
  // Helpers
  // ************************************************************

  task automatic stop_with_error(input string what);
    $display("%s", what);
    $display("tests failed");
    $fatal(1);
  endtask

  // Xorshift generator with its state kept in rng
  function automatic logic [31:0] rand32();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  function automatic logic [31:0] apply_strobes(input logic [31:0] old_w,
                                                input logic [31:0] new_w,
                                                input logic [3:0]  strb);
    logic [31:0] mask;
    mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
    return (old_w & ~mask) | (new_w & mask);
  endfunction

  // Register contents as the map defines them
  function automatic logic [31:0] expected_read(input logic [6:0] addr);
    case (addr[6:2])
      `DEC_REG_VERSION: return `DEC_VERSION_VALUE;
      `DEC_REG_RATIO:   return {16'd0, m_ratio};
      `DEC_REG_CONTROL: return {24'd0, m_shift, 2'b00, m_mode};
      `DEC_REG_SCRATCH: return m_scratch;
      default:          return 32'd0;
    endcase
  endfunction

  // Mode code 3 is not a real mode and runs as bypass
  function automatic dec_dsp_pkg::dec_cfg_t model_cfg();
    dec_dsp_pkg::dec_cfg_t c;
    c.ratio = m_ratio;
    c.shift = m_shift;
    case (m_mode)
      2'd1:    c.mode = dec_dsp_pkg::MODE_PICK;
      2'd2:    c.mode = dec_dsp_pkg::MODE_AVERAGE;
      default: c.mode = dec_dsp_pkg::MODE_BYPASS;
    endcase
    return c;
  endfunction

  task automatic model_write(input logic [4:0] widx, input logic [31:0] data,
                             input logic [3:0] strb);
    logic [31:0] w;
    w = apply_strobes(expected_read({widx, 2'b00}), data, strb);
    case (widx)
      `DEC_REG_RATIO:   m_ratio = (w[15:0] == 16'd0) ? 16'd1 : w[15:0];
      `DEC_REG_CONTROL: begin
        m_mode  = w[1:0];
        m_shift = w[7:4];
      end
      `DEC_REG_SCRATCH: m_scratch = w;
      default: ;
    endcase
  endtask

  // Runs one input sample through the mode rules and returns the output due next cycle
  task automatic model_channel(input int ch, input dec_dsp_pkg::sample_t s,
                               input dec_dsp_pkg::dec_cfg_t c, input logic restart,
                               output dec_dsp_pkg::sample_t e);
    logic signed [31:0] x;
    logic signed [31:0] sum;
    logic signed [31:0] avg;
    logic [16:0]        cnt_next;
    e = '0;
    if (restart) begin
      m_cnt[ch] = 17'd0;
      m_acc[ch] = 32'sd0;
    end
    if (s.valid) begin
      // Shift the 12-bit code to the top and back down to sign extend it
      x = $signed({s.data[`DEC_SAMPLE_WIDTH-1:0], {(32-`DEC_SAMPLE_WIDTH){1'b0}}})
          >>> (32 - `DEC_SAMPLE_WIDTH);
      sum      = m_acc[ch] + x;
      avg      = sum >>> c.shift;
      cnt_next = m_cnt[ch] + 17'd1;
      if (c.mode == dec_dsp_pkg::MODE_BYPASS || (c.mode == dec_dsp_pkg::MODE_PICK &&
          m_cnt[ch] == 17'd0)) begin
        e.valid = 1'b1;
        e.data  = x[15:0];
      end
      if (cnt_next >= {1'b0, c.ratio}) begin
        if (c.mode == dec_dsp_pkg::MODE_AVERAGE) begin
          e.valid = 1'b1;
          e.data  = avg[15:0];
        end
        m_cnt[ch] = 17'd0;
        m_acc[ch] = 32'sd0;
      end else begin
        m_cnt[ch] = cnt_next;
        m_acc[ch] = sum;
      end
    end
  endtask

  // ************************************************************
  // Reference model and output checks
  // ************************************************************

  always @(posedge adc_clk or negedge rst_n) begin
    dec_dsp_pkg::dec_cfg_t cfg_now;
    dec_dsp_pkg::sample_t  next_a;
    dec_dsp_pkg::sample_t  next_b;
    if (!rst_n) begin
      m_ratio   = `DEC_RATIO_RESET;
      m_mode    = 2'd0;
      m_shift   = 4'd0;
      m_scratch = 32'd0;
      m_cnt[0]  = 17'd0;
      m_cnt[1]  = 17'd0;
      m_acc[0]  = 32'sd0;
      m_acc[1]  = 32'sd0;
      cfg_prev  = model_cfg();
      exp_a    <= '0;
      exp_b    <= '0;
    end else begin
      // Channels see the configuration written before this edge
      cfg_now = model_cfg();
      model_channel(0, in_a, cfg_now, cfg_now != cfg_prev, next_a);
      model_channel(1, in_b, cfg_now, cfg_now != cfg_prev, next_b);
      exp_a   <= next_a;
      exp_b   <= next_b;
      cfg_prev = cfg_now;
      if (out_a.valid) n_out_a++;
      if (out_b.valid) n_out_b++;
      if (axi_req.awvalid && axi_req.wvalid && axi_rsp.awready) begin
        model_write(axi_req.awaddr[6:2], axi_req.wdata, axi_req.wstrb);
      end
    end
  end

  assert property (@(posedge adc_clk) disable iff (!rst_n) out_a.valid == exp_a.valid)
    else stop_with_error($sformatf("FAILED out_a.valid expected %h got %h",
                                   $sampled(exp_a.valid), $sampled(out_a.valid)));
  assert property (@(posedge adc_clk) disable iff (!rst_n)
                   !exp_a.valid || out_a.data == exp_a.data)
    else stop_with_error($sformatf("FAILED out_a.data expected %h got %h",
                                   $sampled(exp_a.data), $sampled(out_a.data)));
  assert property (@(posedge adc_clk) disable iff (!rst_n) out_b.valid == exp_b.valid)
    else stop_with_error($sformatf("FAILED out_b.valid expected %h got %h",
                                   $sampled(exp_b.valid), $sampled(out_b.valid)));
  assert property (@(posedge adc_clk) disable iff (!rst_n)
                   !exp_b.valid || out_b.data == exp_b.data)
    else stop_with_error($sformatf("FAILED out_b.data expected %h got %h",
                                   $sampled(exp_b.data), $sampled(out_b.data)));

  always @(posedge adc_clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      stop_with_error("The run went past its cycle limit without finishing");
    end
  end

  // ************************************************************
  // Bus and sample drivers
  // ************************************************************

  task automatic bus_write(input logic [6:0] addr, input logic [31:0] data,
                           input logic [3:0] strb);
    logic [31:0] r;
    @(negedge adc_clk);
    axi_req.awvalid = 1'b1;
    axi_req.awaddr  = addr;
    axi_req.wvalid  = 1'b1;
    axi_req.wdata   = data;
    axi_req.wstrb   = strb;
    @(posedge adc_clk);
    while (!axi_rsp.awready) @(posedge adc_clk);
    assert (axi_rsp.wready && !axi_rsp.bvalid)
      else stop_with_error("Write address and data were not accepted together");
    @(negedge adc_clk);
    axi_req.awvalid = 1'b0;
    axi_req.wvalid  = 1'b0;
    assert (axi_rsp.bvalid)
      else stop_with_error("bvalid did not rise one cycle after the write handshake");
    assert (axi_rsp.bresp == dec_bus_pkg::OKAY)
      else stop_with_error($sformatf("FAILED bresp expected %h got %h",
                                     dec_bus_pkg::OKAY, axi_rsp.bresp));
    // Hold bready low for a random time while bvalid waits
    r = rand32();
    repeat (r[1:0]) begin
      @(negedge adc_clk);
      assert (axi_rsp.bvalid) else stop_with_error("bvalid dropped before bready");
    end
    axi_req.bready = 1'b1;
    @(negedge adc_clk);
    axi_req.bready = 1'b0;
    assert (!axi_rsp.bvalid) else stop_with_error("bvalid stayed high after bready");
  endtask

  task automatic bus_read(input logic [6:0] addr);
    logic [31:0] r;
    logic [31:0] exp_word;
    @(negedge adc_clk);
    axi_req.arvalid = 1'b1;
    axi_req.araddr  = addr;
    @(posedge adc_clk);
    while (!axi_rsp.arready) @(posedge adc_clk);
    assert (!axi_rsp.rvalid) else stop_with_error("Read accepted while rvalid was high");
    @(negedge adc_clk);
    axi_req.arvalid = 1'b0;
    exp_word = expected_read(addr);
    assert (axi_rsp.rvalid)
      else stop_with_error("rvalid did not rise one cycle after the read handshake");
    assert (axi_rsp.rdata == exp_word)
      else stop_with_error($sformatf("FAILED rdata at %h expected %h got %h",
                                     addr, exp_word, axi_rsp.rdata));
    assert (axi_rsp.rresp == dec_bus_pkg::OKAY)
      else stop_with_error($sformatf("FAILED rresp expected %h got %h",
                                     dec_bus_pkg::OKAY, axi_rsp.rresp));
    r = rand32();
    repeat (r[1:0]) begin
      @(negedge adc_clk);
      assert (axi_rsp.rvalid && axi_rsp.rdata == exp_word)
        else stop_with_error("Read response changed before rready");
    end
    axi_req.rready = 1'b1;
    @(negedge adc_clk);
    axi_req.rready = 1'b0;
    assert (!axi_rsp.rvalid) else stop_with_error("rvalid stayed high after rready");
  endtask

  // Random data on both channels with independent gaps
  task automatic drive_samples(input int n);
    logic [31:0] r;
    repeat (n) begin
      @(negedge adc_clk);
      r = rand32();
      in_a.valid = (r[17:16] != 2'b00);
      in_a.data  = r[15:0];
      r = rand32();
      in_b.valid = (r[17:16] != 2'b00);
      in_b.data  = r[15:0];
    end
    @(negedge adc_clk);
    in_a.valid = 1'b0;
    in_b.valid = 1'b0;
  endtask

  // ************************************************************
  // Test sequence
  // ************************************************************

  initial begin
    logic [31:0] r;
    rst_n   = 1'b0;
    axi_req = '0;
    in_a    = '0;
    in_b    = '0;
    repeat (16) @(posedge adc_clk);
    @(negedge adc_clk);
    rst_n = 1'b1;
    @(negedge adc_clk);
    assert (!(axi_rsp.awready | axi_rsp.wready | axi_rsp.arready | axi_rsp.bvalid |
              axi_rsp.rvalid | out_a.valid | out_b.valid))
      else stop_with_error("A valid or ready was high after reset");
    bus_read(7'h00);
    bus_read(7'h04);
    bus_read(7'h08);
    bus_read(7'h0C);

    // Scratch under random strobes, ratio zero, unmapped space
    repeat (8) begin
      r = rand32();
      bus_write(7'h0C, rand32(), r[3:0]);
      bus_read(7'h0C);
    end
    bus_write(7'h04, 32'd0, 4'hF);
    bus_read(7'h04);
    bus_write(7'h10, 32'hFFFF_FFFF, 4'hF);
    bus_read(7'h10);
    bus_read(7'h7C);

    // Bypass at reset configuration
    drive_samples(300);

    // Pick with ratio 5
    bus_write(7'h04, 32'd5, 4'hF);
    bus_write(7'h08, 32'h0000_0001, 4'hF);
    drive_samples(300);

    // Average ratio 8 shift 3, then ratio 3 shift 0 while samples keep flowing
    bus_write(7'h04, 32'd8, 4'hF);
    bus_write(7'h08, 32'h0000_0032, 4'hF);
    fork
      drive_samples(600);
      begin
        repeat (250) @(negedge adc_clk);
        bus_write(7'h04, 32'd3, 4'hF);
        repeat (3) @(negedge adc_clk);
        bus_write(7'h08, 32'h0000_0002, 4'hF);
      end
    join
    repeat (4) @(negedge adc_clk);

    if (n_out_a > 0 && n_out_b > 0) begin
      $display("all tests passed");
      $finish;
    end else begin
      stop_with_error("No output samples were seen on one of the channels");
    end
  end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+.
dec_bus_pkg.sv
dec_dsp_pkg.sv
dec_axi_lite_slave.sv
dec_regs.sv
dec_channel.sv
dec_top.sv
tb_dec_top.sv

// ==== Makefile ====
TOP := tb_dec_top

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f project.f

run: compile
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	grep -q "all tests passed" sim.log

clean:
	rm -rf obj_dir sim.log
